// ==== list.f ====
verilog/qspi_pkg.sv
verilog/qspi_sequencer.sv
verilog/qspi_tx_shifter.sv
verilog/qspi_rx_deserializer.sv
verilog/byte_fifo.sv
verilog/qspi_read_top.sv
sim/flash_model.sv
sim/tb_qspi_read.sv

// ==== Makefile ====
TOP := tb_qspi_read

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== sim/tb_qspi_read.sv ====
`timescale 1ns/1ns

module tb_qspi_read;
    import qspi_pkg::*;

    localparam int NUM_REQUESTS  = 40;
    localparam int DONE_TIMEOUT  = 4000;
    localparam int DRAIN_TIMEOUT = 64;

    logic          system_clk;
    logic          system_reset_n;
    logic          start;
    read_request_t request;
    logic [3:0]    io_in;
    logic          rd_en;
    qspi_pins_t    pins;
    logic          read_done;
    logic [7:0]    rd_data;
    logic          empty;

    logic [7:0]    drained [$];
    int            done_count;

    qspi_read_top DUT (
        .system_clk    (system_clk),
        .system_reset_n(system_reset_n),
        .start         (start),
        .request       (request),
        .io_in         (io_in),
        .rd_en         (rd_en),
        .pins          (pins),
        .read_done     (read_done),
        .rd_data       (rd_data),
        .empty         (empty)
    );

    flash_model flash (
        .pins (pins),
        .io_in(io_in)
    );

    always #4 system_clk = ~system_clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR: %s is %h, expected %h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    // Pop whenever the FIFO shows a byte
    initial
    begin
        rd_en = 1'b0;
        forever
        begin
            @(posedge system_clk);
            #1;
            if (system_reset_n && !empty)
            begin
                drained.push_back(rd_data);
                rd_en = 1'b1;
            end
            else
            begin
                rd_en = 1'b0;
            end
        end
    end

    // Every read_done pulse must come with chip select already high
    initial
    begin
        done_count = 0;
        forever
        begin
            @(negedge system_clk);
            if (read_done)
            begin
                check_value("cs_n at read_done", 32'(pins.cs_n), 32'd1);
                done_count = done_count + 1;
            end
        end
    end

    task automatic issue_request(input read_request_t req);
        @(posedge system_clk);
        #1;
        request = req;
        start   = 1'b1;
        @(posedge system_clk);
        #1;
        start   = 1'b0;
        check_value("cs_n after start", 32'(pins.cs_n), 32'd0);
    endtask

    task automatic wait_for_done(input int target);
        int waited;
        waited = 0;
        while (done_count < target && waited < DONE_TIMEOUT)
        begin
            @(negedge system_clk);
            waited++;
        end
        if (done_count < target)
            abort_run("Timed out waiting for read_done");
    endtask

    task automatic wait_for_empty();
        int waited;
        waited = 0;
        while (!empty && waited < DRAIN_TIMEOUT)
        begin
            @(negedge system_clk);
            waited++;
        end
        if (!empty)
            abort_run("Timed out draining the FIFO");
    endtask

    task automatic check_frames(input read_request_t req, input int base);
        int         rf;
        int         data_slots;
        int         dummy;
        logic [7:0] opcode;
        case (req.mode)
            MODE_DUAL:
            begin
                opcode     = 8'h3C;
                data_slots = int'(req.byte_count) / 2;
                dummy      = 1;
            end
            MODE_QUAD:
            begin
                opcode     = 8'h6C;
                data_slots = int'(req.byte_count) / 4;
                dummy      = 1;
            end
            default:
            begin
                opcode     = 8'h13;
                data_slots = int'(req.byte_count);
                dummy      = 0;
            end
        endcase
        check_value("frame count", 32'(flash.frame_count - base), 32'(1 + int'(req.switch_die)));
        // Separate frames mean chip select went high in between
        if (req.switch_die)
        begin
            check_value("die frame opcode", 32'(flash.frame_opcode[base]), 32'h0000_00c2);
            check_value("die frame id", 32'(flash.frame_die_id[base]), 32'h0000_0001);
            check_value("die frame sclk edges", 32'(flash.frame_edges[base]), 32'd16);
        end
        rf = base + int'(req.switch_die);
        check_value("read opcode", 32'(flash.frame_opcode[rf]), 32'(opcode));
        check_value("read address", flash.frame_addr[rf], req.addr);
        check_value("read sclk edges", 32'(flash.frame_edges[rf]),
                    32'(8 * (5 + dummy + data_slots)));
        check_value("io_oe in data phase", 32'(flash.frame_data_oe[rf]), 32'd0);
        if (dummy == 1)
            check_value("dummy byte", 32'(flash.frame_dummy[rf]), 32'd0);
    endtask

    initial
    begin
        read_request_t req;
        int            frame_base;
        int            read_pos;

        void'($urandom(32'hc48a_df06));
        system_clk     = 1'b0;
        system_reset_n = 1'b0;
        start          = 1'b0;
        request        = '0;
        read_pos       = 0;
        repeat (4) @(posedge system_clk);
        #1;
        system_reset_n = 1'b1;
        @(negedge system_clk);
        check_value("cs_n", 32'(pins.cs_n), 32'd1);
        check_value("sclk", 32'(pins.sclk), 32'd0);
        check_value("io_oe", 32'(pins.io_oe), 32'd0);
        check_value("empty", 32'(empty), 32'd1);
        check_value("read_done", 32'(read_done), 32'd0);

        for (int n = 0; n < NUM_REQUESTS; n++)
        begin
            req.addr       = $urandom;
            req.byte_count = 16'((($urandom % 8) + 1) * 4);
            req.mode       = qspi_mode_e'(2'($urandom % 3));
            req.switch_die = 1'($urandom % 2);
            frame_base     = flash.frame_count;
            issue_request(req);
            wait_for_done(n + 1);
            check_frames(req, frame_base);
            wait_for_empty();
            check_value("read_done pulses", 32'(done_count), 32'(n + 1));
            check_value("bytes drained", 32'(drained.size() - read_pos),
                        32'(req.byte_count));
            for (int i = 0; i < int'(req.byte_count); i++)
                check_value("rd_data", 32'(drained[read_pos + i]),
                            32'(flash.mem[8'(req.addr[7:0] + 8'(i))]));
            read_pos = read_pos + int'(req.byte_count);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sim/flash_model.sv ====
`timescale 1ns/1ns

module flash_model (
    input  qspi_pkg::qspi_pins_t pins,
    output logic [3:0]           io_in
);
    import qspi_pkg::*;

    localparam int MAX_FRAMES = 128;
    localparam int NO_DATA    = 1 << 30;

    logic [7:0]  mem [256];
    logic [7:0]  frame_opcode [MAX_FRAMES];
    logic [7:0]  frame_die_id [MAX_FRAMES];
    logic [31:0] frame_addr [MAX_FRAMES];
    logic [7:0]  frame_dummy [MAX_FRAMES];
    int          frame_edges [MAX_FRAMES];
    logic        frame_data_oe [MAX_FRAMES];
    int          frame_count;

    logic [47:0] cmd_bits;
    logic [7:0]  cur_opcode;
    logic [7:0]  cur_die_id;
    logic [31:0] cur_addr;
    logic [7:0]  cur_dummy;
    logic        cur_data_oe;
    int          edges;
    int          hdr_edges;
    logic        last_sclk;
    logic        last_cs_n;

    // Filled once the run's seed is set
    initial
    begin
        #1;
        for (int i = 0; i < 256; i++)
            mem[i] = 8'($urandom);
    end

    // Lanes for data clock d, high part of each byte first
    function automatic logic [3:0] data_lanes(input int d);
        logic [7:0] b;
        logic [3:0] lanes;
        case (cur_opcode)
            OP_READ_X4:
            begin
                b     = mem[8'(cur_addr[7:0] + 8'(d / 2))];
                lanes = (d % 2 == 0) ? b[7:4] : b[3:0];
            end
            OP_READ_X2:
            begin
                b     = mem[8'(cur_addr[7:0] + 8'(d / 4))];
                lanes = {2'b00, 2'(b >> (6 - 2 * (d % 4)))};
            end
            default:
            begin
                b     = mem[8'(cur_addr[7:0] + 8'(d / 8))];
                lanes = {2'b00, b[3'(7 - d % 8)], 1'b0};
            end
        endcase
        return lanes;
    endfunction

    initial
    begin
        io_in       = 4'b0000;
        frame_count = 0;
        edges       = 0;
        hdr_edges   = NO_DATA;
        last_sclk   = 1'b0;
        last_cs_n   = 1'b1;
        forever
        begin
            @(pins.sclk or pins.cs_n);
            if (last_cs_n === 1'b1 && pins.cs_n === 1'b0)
            begin
                edges       = 0;
                hdr_edges   = NO_DATA;
                cmd_bits    = '0;
                cur_opcode  = 8'h00;
                cur_die_id  = 8'h00;
                cur_addr    = 32'h0;
                cur_dummy   = 8'h00;
                cur_data_oe = 1'b0;
            end
            // Host bits are taken on the rising edge
            if (last_sclk === 1'b0 && pins.sclk === 1'b1)
            begin
                edges = edges + 1;
                if (edges <= 48)
                    cmd_bits = {cmd_bits[46:0], pins.io_out[0]};
                if (edges == 8)
                begin
                    cur_opcode = cmd_bits[7:0];
                    case (cmd_bits[7:0])
                        OP_READ_X1:             hdr_edges = 40;
                        OP_READ_X2, OP_READ_X4: hdr_edges = 48;
                        default:                hdr_edges = NO_DATA;
                    endcase
                end
                if (edges == 16)
                    cur_die_id = cmd_bits[7:0];
                if (edges == 40)
                    cur_addr = cmd_bits[31:0];
                if (edges == 48)
                    cur_dummy = cmd_bits[7:0];
                if (edges > hdr_edges && pins.io_oe != 4'b0000)
                    cur_data_oe = 1'b1;
            end
            if (last_sclk === 1'b1 && pins.sclk === 1'b0 && edges >= hdr_edges)
                io_in = data_lanes(edges - hdr_edges);
            if (last_cs_n === 1'b0 && pins.cs_n === 1'b1)
            begin
                if (frame_count < MAX_FRAMES)
                begin
                    frame_opcode[frame_count]  = cur_opcode;
                    frame_die_id[frame_count]  = cur_die_id;
                    frame_addr[frame_count]    = cur_addr;
                    frame_dummy[frame_count]   = cur_dummy;
                    frame_edges[frame_count]   = edges;
                    frame_data_oe[frame_count] = cur_data_oe;
                end
                frame_count = frame_count + 1;
            end
            last_sclk = pins.sclk;
            last_cs_n = pins.cs_n;
        end
    end

endmodule

// ==== verilog/qspi_read_top.sv ====
`timescale 1ns/1ns

module qspi_read_top #(
    parameter int SCLK_DIV   = 4,
    parameter int FIFO_DEPTH = 256
) (
    input  logic                    system_clk,
    input  logic                    system_reset_n,
    input  logic                    start,
    input  qspi_pkg::read_request_t request,
    input  logic [3:0]              io_in,
    input  logic                    rd_en,
    output qspi_pkg::qspi_pins_t    pins,
    output logic                    read_done,
    output logic [7:0]              rd_data,
    output logic                    empty
);
    import qspi_pkg::*;

    read_request_t req;
    bus_step_t     step;
    logic          sclk;
    logic          cs_n;
    logic [3:0]    io_out;
    logic [3:0]    io_oe;
    logic          byte_valid;
    logic [7:0]    byte_data;

    qspi_sequencer #(
        .SCLK_DIV(SCLK_DIV)
    ) u_sequencer (
        .system_clk    (system_clk),
        .system_reset_n(system_reset_n),
        .start         (start),
        .request       (request),
        .req           (req),
        .step          (step),
        .sclk          (sclk),
        .cs_n          (cs_n),
        .read_done     (read_done)
    );

    qspi_tx_shifter u_tx_shifter (
        .system_clk    (system_clk),
        .system_reset_n(system_reset_n),
        .step          (step),
        .req           (req),
        .io_out        (io_out),
        .io_oe         (io_oe)
    );

    qspi_rx_deserializer u_rx_deserializer (
        .system_clk    (system_clk),
        .system_reset_n(system_reset_n),
        .step          (step),
        .req           (req),
        .io_in         (io_in),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data)
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .system_clk    (system_clk),
        .system_reset_n(system_reset_n),
        .wr_en         (byte_valid),
        .wr_data       (byte_data),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .empty         (empty)
    );

    // Pad-side bundle
    assign pins.sclk   = sclk;
    assign pins.cs_n   = cs_n;
    assign pins.io_out = io_out;
    assign pins.io_oe  = io_oe;

endmodule

// ==== verilog/byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic       system_clk,
    input  logic       system_reset_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [7:0]        mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    assign full  = (count == (ADDR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry always visible on rd_data
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge system_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + ADDR_W'(1);
            if (do_rd)
                rd_ptr <= rd_ptr + ADDR_W'(1);
            if (do_wr && !do_rd)
                count <= count + (ADDR_W + 1)'(1);
            else if (do_rd && !do_wr)
                count <= count - (ADDR_W + 1)'(1);
        end
    end

endmodule

// ==== verilog/qspi_rx_deserializer.sv ====
`timescale 1ns/1ns

module qspi_rx_deserializer (
    input  logic                    system_clk,
    input  logic                    system_reset_n,
    input  qspi_pkg::bus_step_t     step,
    input  qspi_pkg::read_request_t req,
    input  logic [3:0]              io_in,
    output logic                    byte_valid,
    output logic [7:0]              byte_data
);
    import qspi_pkg::*;

    logic [7:0] shift_reg;
    logic [7:0] shift_next;
    logic [2:0] sample_cnt;
    logic [2:0] last_cnt;
    logic       data_sample;
    logic       byte_last;

    // Earlier samples land in the upper bits
    always_comb
    begin
        case (req.mode)
            MODE_DUAL:
            begin
                shift_next = {shift_reg[5:0], io_in[1], io_in[0]};
                last_cnt   = 3'd3;
            end
            MODE_QUAD:
            begin
                shift_next = {shift_reg[3:0], io_in[3:0]};
                last_cnt   = 3'd1;
            end
            default:
            begin
                shift_next = {shift_reg[6:0], io_in[1]};
                last_cnt   = 3'd7;
            end
        endcase
    end

    assign data_sample = step.sample && (step.kind == SLOT_DATA);
    assign byte_last   = (sample_cnt == last_cnt);

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
            sample_cnt <= '0;
        else if (step.kind != SLOT_DATA)
            sample_cnt <= '0;
        else if (data_sample)
            sample_cnt <= byte_last ? 3'd0 : sample_cnt + 3'd1;
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
            byte_valid <= 1'b0;
        else
            byte_valid <= data_sample && byte_last;
    end

    always_ff @(posedge system_clk)
    begin
        if (data_sample)
            shift_reg <= shift_next;
        if (data_sample && byte_last)
            byte_data <= shift_next;
    end

endmodule

// ==== verilog/qspi_tx_shifter.sv ====
`timescale 1ns/1ns

module qspi_tx_shifter (
    input  logic                    system_clk,
    input  logic                    system_reset_n,
    input  qspi_pkg::bus_step_t     step,
    input  qspi_pkg::read_request_t req,
    output logic [3:0]              io_out,
    output logic [3:0]              io_oe
);
    import qspi_pkg::*;

    logic [7:0] read_opcode;
    logic [7:0] addr_sel;
    logic [7:0] tx_byte;
    logic       drive;

    always_comb
    begin
        case (req.mode)
            MODE_DUAL: read_opcode = OP_READ_X2;
            MODE_QUAD: read_opcode = OP_READ_X4;
            default:   read_opcode = OP_READ_X1;
        endcase
    end

    // High address byte goes out first
    always_comb
    begin
        case (step.addr_byte)
            2'd0:    addr_sel = req.addr[31:24];
            2'd1:    addr_sel = req.addr[23:16];
            2'd2:    addr_sel = req.addr[15:8];
            default: addr_sel = req.addr[7:0];
        endcase
    end

    always_comb
    begin
        case (step.kind)
            SLOT_OPCODE: tx_byte = read_opcode;
            SLOT_DIE_ID: tx_byte = (step.addr_byte == 2'd0) ? OP_DIE_SELECT : DIE_ID;
            SLOT_ADDR:   tx_byte = addr_sel;
            default:     tx_byte = 8'h00;
        endcase
    end

    // Host owns io0 until the data phase
    assign drive = (step.kind == SLOT_OPCODE) || (step.kind == SLOT_DIE_ID)
                || (step.kind == SLOT_ADDR) || (step.kind == SLOT_DUMMY);

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            io_out <= 4'b0000;
            io_oe  <= 4'b0000;
        end
        else if (step.kind == SLOT_NONE)
        begin
            io_out <= 4'b0000;
            io_oe  <= 4'b0000;
        end
        else if (step.launch)
        begin
            io_out <= {3'b000, tx_byte[3'd7 - step.bit_idx]};
            io_oe  <= {3'b000, drive};
        end
    end

endmodule

// ==== verilog/qspi_sequencer.sv ====
`timescale 1ns/1ns

module qspi_sequencer #(
    parameter int SCLK_DIV = 4
) (
    input  logic                    system_clk,
    input  logic                    system_reset_n,
    input  logic                    start,
    input  qspi_pkg::read_request_t request,
    output qspi_pkg::read_request_t req,
    output qspi_pkg::bus_step_t     step,
    output logic                    sclk,
    output logic                    cs_n,
    output logic                    read_done
);
    import qspi_pkg::*;

    localparam int PHASE_W = $clog2(SCLK_DIV);
    localparam int HALF = SCLK_DIV / 2;

    frame_state_e       state;
    logic [PHASE_W-1:0] phase;
    logic [2:0]         bit_cnt;
    logic [16:0]        slot_cnt;
    logic [16:0]        data_slots;
    logic [16:0]        last_slot;
    logic               use_dummy;
    logic               counting;
    logic               bus_active;
    logic               phase_end;
    logic               slot_end;

    assign counting   = (state == ST_DIE_SELECT) || (state == ST_GAP) || (state == ST_READ);
    assign bus_active = (state == ST_DIE_SELECT) || (state == ST_READ);
    assign phase_end  = (phase == PHASE_W'(SCLK_DIV - 1));
    assign slot_end   = counting && phase_end && (bit_cnt == 3'd7);

    // Data slots scale with the lane count
    always_comb
    begin
        case (req.mode)
            MODE_DUAL: data_slots = {2'b00, req.byte_count[15:1]};
            MODE_QUAD: data_slots = {3'b000, req.byte_count[15:2]};
            default:   data_slots = {1'b0, req.byte_count};
        endcase
    end

    assign use_dummy = (req.mode != MODE_SINGLE);
    // Opcode at slot 0, address after it, then dummy and data
    assign last_slot = 17'(ADDR_BYTES) + {16'd0, use_dummy} + data_slots;

    always_ff @(posedge system_clk)
    begin
        if (state == ST_IDLE && start)
            req <= request;
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            phase   <= '0;
            bit_cnt <= '0;
        end
        else if (!counting)
        begin
            phase   <= '0;
            bit_cnt <= '0;
        end
        else if (phase_end)
        begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 3'd1;
        end
        else
        begin
            phase <= phase + PHASE_W'(1);
        end
    end

    // Low from the launch cycle, high from the sample cycle
    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
            sclk <= 1'b0;
        else if (!bus_active || phase_end)
            sclk <= 1'b0;
        else if (phase == PHASE_W'(HALF - 1))
            sclk <= 1'b1;
    end

    always_ff @(posedge system_clk or negedge system_reset_n)
    begin
        if (!system_reset_n)
        begin
            state     <= ST_IDLE;
            cs_n      <= 1'b1;
            read_done <= 1'b0;
            slot_cnt  <= '0;
        end
        else
        begin
            read_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state    <= request.switch_die ? ST_DIE_SELECT : ST_READ;
                        cs_n     <= 1'b0;
                        slot_cnt <= '0;
                    end
                end
                ST_DIE_SELECT:
                begin
                    if (slot_end && slot_cnt == 17'd1)
                    begin
                        state    <= ST_GAP;
                        cs_n     <= 1'b1;
                        slot_cnt <= '0;
                    end
                    else if (slot_end)
                    begin
                        slot_cnt <= slot_cnt + 17'd1;
                    end
                end
                // Chip select high for one slot between frames
                ST_GAP:
                begin
                    if (slot_end)
                    begin
                        state <= ST_READ;
                        cs_n  <= 1'b0;
                    end
                end
                ST_READ:
                begin
                    if (slot_end && slot_cnt == last_slot)
                    begin
                        state <= ST_COMPLETE;
                        cs_n  <= 1'b1;
                    end
                    else if (slot_end)
                    begin
                        slot_cnt <= slot_cnt + 17'd1;
                    end
                end
                ST_COMPLETE:
                begin
                    read_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                    cs_n  <= 1'b1;
                end
            endcase
        end
    end

    // Die-select frame sends the command byte and then the die number
    always_comb
    begin
        step.kind      = SLOT_NONE;
        step.addr_byte = slot_cnt[1:0];
        step.bit_idx   = bit_cnt;
        step.launch    = bus_active && (phase == '0);
        step.sample    = bus_active && (phase == PHASE_W'(HALF));
        if (state == ST_DIE_SELECT)
        begin
            step.kind = SLOT_DIE_ID;
        end
        else if (state == ST_READ)
        begin
            if (slot_cnt == '0)
            begin
                step.kind = SLOT_OPCODE;
            end
            else if (slot_cnt <= 17'(ADDR_BYTES))
            begin
                step.kind      = SLOT_ADDR;
                step.addr_byte = slot_cnt[1:0] - 2'd1;
            end
            else if (use_dummy && slot_cnt == 17'(ADDR_BYTES + 1))
            begin
                step.kind = SLOT_DUMMY;
            end
            else
            begin
                step.kind = SLOT_DATA;
            end
        end
    end

endmodule

// ==== verilog/qspi_pkg.sv ====
package qspi_pkg;

    // Data phase bus width
    typedef enum logic [1:0] {
        MODE_SINGLE = 2'd0,
        MODE_DUAL   = 2'd1,
        MODE_QUAD   = 2'd2
    } qspi_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_DIE_SELECT = 3'd1,
        ST_GAP        = 3'd2,
        ST_READ       = 3'd3,
        ST_COMPLETE   = 3'd4
    } frame_state_e;

    // Flash command bytes
    typedef enum logic [7:0] {
        OP_READ_X1    = 8'h13,
        OP_READ_X2    = 8'h3C,
        OP_READ_X4    = 8'h6C,
        OP_DIE_SELECT = 8'hC2
    } flash_opcode_e;

    // Content of one 8-clock slot
    typedef enum logic [2:0] {
        SLOT_NONE   = 3'd0,
        SLOT_OPCODE = 3'd1,
        SLOT_DIE_ID = 3'd2,
        SLOT_ADDR   = 3'd3,
        SLOT_DUMMY  = 3'd4,
        SLOT_DATA   = 3'd5
    } slot_kind_e;

    localparam logic [7:0] DIE_ID = 8'h01;
    localparam int ADDR_BYTES = 4;

    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] byte_count;
        qspi_mode_e  mode;
        logic        switch_die;
    } read_request_t;

    // Per-cycle bus position issued by the sequencer
    typedef struct packed {
        slot_kind_e  kind;
        logic [1:0]  addr_byte;
        logic [2:0]  bit_idx;
        logic        launch;
        logic        sample;
    } bus_step_t;

    typedef struct packed {
        logic        sclk;
        logic        cs_n;
        logic [3:0]  io_out;
        logic [3:0]  io_oe;
    } qspi_pins_t;

endpackage
